/* source/cpu_pkg.sv */
package cpu_pkg;

    localparam int data_w    = 16;                  // Datapath word width
    localparam int reg_idx_w = 4;                   // Register index width

    // Opcodes in instr[15:12]
    localparam logic [3:0] op_add  = 4'd0;
    localparam logic [3:0] op_sub  = 4'd1;
    localparam logic [3:0] op_and  = 4'd2;
    localparam logic [3:0] op_or   = 4'd3;
    localparam logic [3:0] op_xor  = 4'd4;
    localparam logic [3:0] op_sll  = 4'd5;
    localparam logic [3:0] op_sra  = 4'd6;
    localparam logic [3:0] op_ror  = 4'd7;
    localparam logic [3:0] op_addi = 4'd8;          // rd = rd + sext(imm8)
    localparam logic [3:0] op_llb  = 4'd9;          // Load low byte of rd
    localparam logic [3:0] op_lhb  = 4'd10;         // Load high byte of rd
    localparam logic [3:0] op_hlt  = 4'd15;         // Stops the core

    // Bit positions inside the 3-bit flags word
    localparam int flag_z = 2;                      // Zero
    localparam int flag_v = 1;                      // Signed overflow
    localparam int flag_n = 0;                      // Negative

    // Register format with opcode rd rs rt
    typedef struct packed {
        logic [3:0]           opcode;
        logic [reg_idx_w-1:0] rd;                   // Destination
        logic [reg_idx_w-1:0] rs;                   // First source
        logic [reg_idx_w-1:0] rt;                   // Second source
    } r_fmt_t;

    // Immediate format with opcode rd imm8
    typedef struct packed {
        logic [3:0]           opcode;
        logic [reg_idx_w-1:0] rd;                   // Destination and source
        logic [7:0]           imm8;                 // Byte constant
    } i_fmt_t;

    // One instruction word read two ways
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_word_u;

endpackage

/* source/ex_bus_if.sv */
`timescale 1ns/1ps

interface ex_bus_if;

    logic                           valid;          // Low for a bubble
    logic [3:0]                     op;             // Opcode drives the ALU directly
    logic                           alu_src;        // Immediate into ALU input b
    logic                           reg_write;      // Result goes to the register file
    logic                           flag_en;        // Instruction updates flags
    logic [cpu_pkg::reg_idx_w-1:0]  rr1_reg;        // Source register numbers for forwarding
    logic [cpu_pkg::reg_idx_w-1:0]  rr2_reg;
    logic [cpu_pkg::reg_idx_w-1:0]  wr_reg;         // Destination register
    logic [cpu_pkg::data_w-1:0]     rr1_data;       // Operand values read in decode
    logic [cpu_pkg::data_w-1:0]     rr2_data;
    logic [cpu_pkg::data_w-1:0]     imm_value;      // Extended imm8

    // Decode side owns the ID/EX register
    modport src (
        output valid, op, alu_src, reg_write, flag_en,
        output rr1_reg, rr2_reg, wr_reg,
        output rr1_data, rr2_data, imm_value
    );

    // Execute side only reads it
    modport dst (
        input valid, op, alu_src, reg_write, flag_en,
        input rr1_reg, rr2_reg, wr_reg,
        input rr1_data, rr2_data, imm_value
    );

endinterface

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [cpu_pkg::reg_idx_w-1:0] rd_idx1,   // Read port 1
    input  logic [cpu_pkg::reg_idx_w-1:0] rd_idx2,   // Read port 2
    output logic [cpu_pkg::data_w-1:0]    rd_data1,
    output logic [cpu_pkg::data_w-1:0]    rd_data2,
    input  logic                          wr_en,     // Write port from write-back
    input  logic [cpu_pkg::reg_idx_w-1:0] wr_idx,
    input  logic [cpu_pkg::data_w-1:0]    wr_data
);

    localparam int num_regs = 2 ** cpu_pkg::reg_idx_w;

    logic [cpu_pkg::data_w-1:0] regs [num_regs];      // R0 is writable like the rest
    logic                       hit1;
    logic                       hit2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};                   // Core starts from all zeros
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Same-cycle write shows up on the read ports
    // This covers the distance-2 hazard in decode
    assign hit1 = wr_en && (wr_idx == rd_idx1);
    assign hit2 = wr_en && (wr_idx == rd_idx2);

    always_comb begin
        rd_data1 = regs[rd_idx1];                     // Plain array read
        rd_data2 = regs[rd_idx2];
        if (hit1) begin
            rd_data1 = wr_data;                       // Bypass port 1
        end
        if (hit2) begin
            rd_data2 = wr_data;                       // Bypass port 2
        end
    end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  logic [cpu_pkg::data_w-1:0]    in_instr,
    output logic                          in_ready,
    output logic                          halted,
    output logic [cpu_pkg::reg_idx_w-1:0] rd_idx1,   // Register file read addresses
    output logic [cpu_pkg::reg_idx_w-1:0] rd_idx2,
    input  logic [cpu_pkg::data_w-1:0]    rd_data1,
    input  logic [cpu_pkg::data_w-1:0]    rd_data2,
    ex_bus_if.src                         bus        // ID/EX register
);

    cpu_pkg::instr_word_u       instr;
    logic                       accept;
    logic                       is_imm;
    logic                       is_addi;
    logic                       is_hlt;
    logic                       sets_flags;
    logic [cpu_pkg::data_w-1:0] imm_ext;

    assign instr    = in_instr;                       // Same bits, two views
    assign in_ready = ~halted;                        // Closed for good after HLT
    assign accept   = in_valid & in_ready;            // Beat transfers this edge

    assign is_addi = (instr.i_fmt.opcode == cpu_pkg::op_addi);
    assign is_hlt  = (instr.i_fmt.opcode == cpu_pkg::op_hlt);
    assign is_imm  = is_addi
                   || (instr.i_fmt.opcode == cpu_pkg::op_llb)
                   || (instr.i_fmt.opcode == cpu_pkg::op_lhb);

    always_comb begin
        case (instr.r_fmt.opcode)
            cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_addi,
            cpu_pkg::op_and, cpu_pkg::op_or, cpu_pkg::op_xor: sets_flags = 1'b1;
            default:                                          sets_flags = 1'b0;
        endcase
    end

    // Immediate ops use rd as their first operand
    assign rd_idx1 = is_imm ? instr.i_fmt.rd : instr.r_fmt.rs;
    assign rd_idx2 = instr.r_fmt.rt;                  // Unused when alu_src is set

    // ADDI sign-extends, LLB and LHB zero-extend
    assign imm_ext = is_addi ? {{8{instr.i_fmt.imm8[7]}}, instr.i_fmt.imm8}
                             : {8'h00, instr.i_fmt.imm8};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted        <= 1'b0;
            bus.valid     <= 1'b0;
            bus.reg_write <= 1'b0;
            bus.flag_en   <= 1'b0;
        end else begin
            if (accept && is_hlt) begin
                halted <= 1'b1;                       // Sticky
            end
            bus.valid     <= accept;                  // Bubble when nothing arrives
            bus.reg_write <= ~is_hlt;                 // HLT writes nothing
            bus.flag_en   <= sets_flags;              // Qualified by valid in execute
        end
    end

    // Payload half of ID/EX is loaded every cycle
    always_ff @(posedge clk) begin
        bus.op        <= instr.r_fmt.opcode;
        bus.alu_src   <= is_imm;
        bus.rr1_reg   <= rd_idx1;
        bus.rr2_reg   <= rd_idx2;
        bus.wr_reg    <= instr.r_fmt.rd;
        bus.rr1_data  <= rd_data1;                    // May be stale and is forwarded in execute
        bus.rr2_data  <= rd_data2;
        bus.imm_value <= imm_ext;
    end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::data_w-1:0] a,
    input  logic [cpu_pkg::data_w-1:0] b,
    input  logic [3:0]                 op,
    output logic [cpu_pkg::data_w-1:0] result,
    output logic [2:0]                 flags          // Z, V, N
);

    logic [cpu_pkg::data_w-1:0]   sum;
    logic [cpu_pkg::data_w-1:0]   diff;
    logic [2*cpu_pkg::data_w-1:0] rot;
    logic [3:0]                   shamt;
    logic                         ovf_add;
    logic                         ovf_sub;
    logic                         ovf;

    assign shamt = b[3:0];                            // Shift amount 0..15
    assign sum   = a + b;                             // Wraps at 16 bits
    assign diff  = a - b;
    assign rot   = {a, a} >> shamt;                   // Rotate via doubled word

    // Signed overflow when the result sign breaks the sign rule of a
    assign ovf_add = (a[15] == b[15]) && (sum[15] != a[15]);
    assign ovf_sub = (a[15] != b[15]) && (diff[15] != a[15]);

    always_comb begin
        ovf = 1'b0;                                   // Only arithmetic reports V
        case (op)
            cpu_pkg::op_add,
            cpu_pkg::op_addi: begin
                result = sum;
                ovf    = ovf_add;
            end
            cpu_pkg::op_sub: begin
                result = diff;
                ovf    = ovf_sub;
            end
            cpu_pkg::op_and: result = a & b;
            cpu_pkg::op_or:  result = a | b;
            cpu_pkg::op_xor: result = a ^ b;
            cpu_pkg::op_sll: result = a << shamt;
            cpu_pkg::op_sra: result = $unsigned($signed(a) >>> shamt);  // Keeps sign
            cpu_pkg::op_ror: result = rot[cpu_pkg::data_w-1:0];
            cpu_pkg::op_llb: result = {a[15:8], b[7:0]};                // Replace low byte
            cpu_pkg::op_lhb: result = {b[7:0], a[7:0]};                 // Replace high byte
            default:         result = '0;
        endcase
    end

    always_comb begin
        flags[cpu_pkg::flag_z] = (result == '0);
        flags[cpu_pkg::flag_v] = ovf;
        flags[cpu_pkg::flag_n] = result[15];          // Sign bit
    end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    ex_bus_if.dst                         bus,        // ID/EX register
    output logic                          wb_valid,   // EX/MEM outputs to write-back
    output logic [cpu_pkg::reg_idx_w-1:0] wb_reg,
    output logic [cpu_pkg::data_w-1:0]    wb_data,
    output logic [2:0]                    flags
);

    logic                          exm_write;         // EX/MEM write enable
    logic [cpu_pkg::reg_idx_w-1:0] exm_reg;
    logic [cpu_pkg::data_w-1:0]    exm_data;
    logic                          fwd1;
    logic                          fwd2;
    logic [cpu_pkg::data_w-1:0]    op_a;
    logic [cpu_pkg::data_w-1:0]    op_b;
    logic [cpu_pkg::data_w-1:0]    alu_b;
    logic [cpu_pkg::data_w-1:0]    alu_result;
    logic [2:0]                    alu_flags;
    logic [2:0]                    flag_reg;
    logic                          is_arith;

    // Instruction i+1 takes its stale operand from EX/MEM
    assign fwd1 = exm_write && (exm_reg == bus.rr1_reg);
    assign fwd2 = exm_write && (exm_reg == bus.rr2_reg);
    assign op_a = fwd1 ? exm_data : bus.rr1_data;
    assign op_b = fwd2 ? exm_data : bus.rr2_data;

    assign alu_b = bus.alu_src ? bus.imm_value : op_b;    // Immediate or register

    alu i_alu (
        .a      (op_a),
        .b      (alu_b),
        .op     (bus.op),
        .result (alu_result),
        .flags  (alu_flags)
    );

    // Arithmetic loads all three flags and logic ops leave V alone
    assign is_arith = (bus.op == cpu_pkg::op_add)
                   || (bus.op == cpu_pkg::op_sub)
                   || (bus.op == cpu_pkg::op_addi);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exm_write <= 1'b0;
            flag_reg  <= '0;
        end else begin
            exm_write <= bus.valid & bus.reg_write;   // Bubbles and HLT write nothing
            if (bus.valid && bus.flag_en) begin
                flag_reg[cpu_pkg::flag_z] <= alu_flags[cpu_pkg::flag_z];
                flag_reg[cpu_pkg::flag_n] <= alu_flags[cpu_pkg::flag_n];
                if (is_arith) begin
                    flag_reg[cpu_pkg::flag_v] <= alu_flags[cpu_pkg::flag_v];
                end
            end
        end
    end

    // Result payload of EX/MEM
    always_ff @(posedge clk) begin
        exm_reg  <= bus.wr_reg;
        exm_data <= alu_result;
    end

    assign wb_valid = exm_write;
    assign wb_reg   = exm_reg;
    assign wb_data  = exm_data;
    assign flags    = flag_reg;                       // Same edge as EX/MEM

endmodule

/* source/exec_core.sv */
`timescale 1ns/1ps

module exec_core (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  logic [cpu_pkg::data_w-1:0]    in_instr,
    output logic                          in_ready,
    output logic                          res_valid,  // One per non-HLT instruction
    output logic [cpu_pkg::reg_idx_w-1:0] res_reg,
    output logic [cpu_pkg::data_w-1:0]    res_data,
    output logic [2:0]                    flags,      // Z, V, N
    output logic                          halted
);

    logic [cpu_pkg::reg_idx_w-1:0] rd_idx1;
    logic [cpu_pkg::reg_idx_w-1:0] rd_idx2;
    logic [cpu_pkg::data_w-1:0]    rd_data1;
    logic [cpu_pkg::data_w-1:0]    rd_data2;

    ex_bus_if id_ex ();                               // ID/EX bundle

    decode_stage i_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_ready (in_ready),
        .halted   (halted),
        .rd_idx1  (rd_idx1),
        .rd_idx2  (rd_idx2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .bus      (id_ex.src)
    );

    // Write port fed straight from EX/MEM
    reg_file i_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_idx1  (rd_idx1),
        .rd_idx2  (rd_idx2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wr_en    (res_valid),
        .wr_idx   (res_reg),
        .wr_data  (res_data)
    );

    execute_stage i_execute (
        .clk      (clk),
        .arst_n   (arst_n),
        .bus      (id_ex.dst),
        .wb_valid (res_valid),
        .wb_reg   (res_reg),
        .wb_data  (res_data),
        .flags    (flags)
    );

endmodule

/* dv/exec_core_tb.sv */
`timescale 1ns/1ps

module exec_core_tb;

    typedef struct packed {
        logic [15:0] instr;
        int          gap;                                // Idle cycles after the beat
        logic [3:0]  exp_reg;
        logic [15:0] exp_data;
        logic [2:0]  exp_flags;                          // Z V N
    } step_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        in_valid;
    logic [15:0] in_instr;
    logic        in_ready;
    logic        res_valid;
    logic [3:0]  res_reg;
    logic [15:0] res_data;
    logic [2:0]  flags;
    logic        halted;

    step_t steps [$];                                    // Stimulus and expected results
    int    exp_idx          = 0;                         // Next entry the checker expects
    int    result_count     = 0;
    int    expected_results = 0;
    int    cycle_count      = 0;
    int    timeout_cycles   = 0;

    exec_core i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_ready  (in_ready),
        .res_valid (res_valid),
        .res_reg   (res_reg),
        .res_data  (res_data),
        .flags     (flags),
        .halted    (halted)
    );

    always #20 clk = ~clk;                               // 40 ns period

    task automatic stop_on_failure();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, expected);
            stop_on_failure();
        end
    endtask

    function automatic bit is_halt(input logic [15:0] instr);
        cpu_pkg::instr_word_u w;
        w = instr;
        return w.r_fmt.opcode == cpu_pkg::op_hlt;
    endfunction

    task automatic add_step(input logic [15:0] instr, input int gap, input logic [3:0] exp_reg,
                            input logic [15:0] exp_data, input logic [2:0] exp_flags);
        step_t s;
        s = '{instr, gap, exp_reg, exp_data, exp_flags};
        steps.push_back(s);
    endtask

    // Expected values worked out by hand from an all-zero register file
    task automatic load_table();
        add_step(16'h81FD, 0, 4'h1, 16'hFFFD, 3'b001);  // ADDI r1, -3
        add_step(16'h827F, 0, 4'h2, 16'h007F, 3'b000);  // ADDI r2, 0x7F
        add_step(16'h9334, 0, 4'h3, 16'h0034, 3'b000);  // LLB r3
        add_step(16'hA312, 0, 4'h3, 16'h1234, 3'b000);  // LHB r3 on the same register
        add_step(16'h9155, 0, 4'h1, 16'hFF55, 3'b000);  // LLB keeps high byte
        add_step(16'h8401, 0, 4'h4, 16'h0001, 3'b000);  // Shift amount 1
        add_step(16'h850F, 0, 4'h5, 16'h000F, 3'b000);  // Shift amount 15
        add_step(16'h0622, 0, 4'h6, 16'h00FE, 3'b000);  // ADD
        add_step(16'h1733, 0, 4'h7, 16'h0000, 3'b100);  // SUB to zero
        add_step(16'h1823, 0, 4'h8, 16'hEE4B, 3'b001);  // SUB negative
        add_step(16'hA97F, 0, 4'h9, 16'h7F00, 3'b001);
        add_step(16'h99FF, 0, 4'h9, 16'h7FFF, 3'b001);  // r9 = max positive
        add_step(16'h0A94, 0, 4'hA, 16'h8000, 3'b011);  // ADD overflow
        add_step(16'h1BA4, 0, 4'hB, 16'h7FFF, 3'b010);  // SUB overflow
        add_step(16'h0C11, 0, 4'hC, 16'hFEAA, 3'b001);  // Negative plus negative without V
        add_step(16'h0D99, 0, 4'hD, 16'hFFFE, 3'b011);  // Sets V before logic ops
        add_step(16'h2E32, 0, 4'hE, 16'h0034, 3'b010);  // AND keeps V
        add_step(16'h3EEA, 0, 4'hE, 16'h8034, 3'b011);  // OR
        add_step(16'h4F33, 0, 4'hF, 16'h0000, 3'b110);  // XOR to zero
        add_step(16'h5630, 0, 4'h6, 16'h1234, 3'b110);  // SLL by 0
        add_step(16'h5734, 0, 4'h7, 16'h2468, 3'b110);  // SLL by 1
        add_step(16'h5845, 0, 4'h8, 16'h8000, 3'b110);  // SLL by 15
        add_step(16'h66A4, 0, 4'h6, 16'hC000, 3'b110);  // SRA by 1
        add_step(16'h6715, 0, 4'h7, 16'hFFFF, 3'b110);  // SRA by 15
        add_step(16'h6810, 0, 4'h8, 16'hFF55, 3'b110);  // SRA by 0
        add_step(16'h7634, 0, 4'h6, 16'h091A, 3'b110);  // ROR by 1
        add_step(16'h7735, 0, 4'h7, 16'h2468, 3'b110);  // ROR by 15
        add_step(16'h7830, 0, 4'h8, 16'h1234, 3'b110);  // ROR by 0
        add_step(16'h8402, 0, 4'h4, 16'h0003, 3'b000);  // Chain with no gap
        add_step(16'h0544, 0, 4'h5, 16'h0006, 3'b000);  // EX/MEM forward
        add_step(16'h0645, 0, 4'h6, 16'h0009, 3'b000);  // r4 via bypass and r5 forwarded
        add_step(16'h1764, 0, 4'h7, 16'h0006, 3'b000);
        add_step(16'h8405, 1, 4'h4, 16'h0008, 3'b000);  // Chain with gap 1
        add_step(16'h0544, 1, 4'h5, 16'h0010, 3'b000);
        add_step(16'h0645, 1, 4'h6, 16'h0018, 3'b000);
        add_step(16'h1764, 1, 4'h7, 16'h0010, 3'b000);
        add_step(16'h84FF, 3, 4'h4, 16'h0007, 3'b000);  // Chain with gap 3
        add_step(16'h0544, 3, 4'h5, 16'h000E, 3'b000);
        add_step(16'h0645, 3, 4'h6, 16'h0015, 3'b000);
        add_step(16'h1746, 3, 4'h7, 16'hFFF2, 3'b001);
        add_step(16'h8810, 0, 4'h8, 16'h1244, 3'b000);  // Still in flight at HLT
        add_step(16'hF000, 0, 4'h0, 16'h0000, 3'b000);  // HLT gives no result
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic send_instr(input logic [15:0] instr);
        in_valid = 1'b1;
        in_instr = instr;
        while (!in_ready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);                                  // Beat transfers here
        #2;
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        int max_gap;
        in_valid = 1'b0;
        in_instr = '0;
        arst_n   = 1'b0;
        load_table();
        max_gap = 0;
        foreach (steps[i]) begin
            if (steps[i].gap > max_gap) begin
                max_gap = steps[i].gap;
            end
            if (!is_halt(steps[i].instr)) begin
                expected_results++;
            end
        end
        timeout_cycles = steps.size() * max_gap + 40;
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        foreach (steps[i]) begin
            send_instr(steps[i].instr);
            idle_cycles(steps[i].gap);
        end
        check_value("halted", {15'd0, halted}, 16'h0001);
        check_value("in_ready", {15'd0, in_ready}, 16'h0000);
        in_valid = 1'b1;                                 // Offered after halt and never taken
        in_instr = 16'h8901;
        repeat (10) begin
            @(posedge clk);
            #2;
            check_value("in_ready", {15'd0, in_ready}, 16'h0000);
        end
        in_valid = 1'b0;
        idle_cycles(4);
        if (result_count != expected_results) begin
            $display("Saw %0d results where %0d were expected", result_count, expected_results);
            stop_on_failure();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

    // In-order checker sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n && res_valid) begin
            while (exp_idx < steps.size() && is_halt(steps[exp_idx].instr)) begin
                exp_idx++;                               // HLT gives no result
            end
            if (exp_idx >= steps.size()) begin
                $display("Result for r%0d arrived after all expected results", res_reg);
                stop_on_failure();
            end else begin
                check_value("res_reg", {12'd0, res_reg}, {12'd0, steps[exp_idx].exp_reg});
                check_value("res_data", res_data, steps[exp_idx].exp_data);
                check_value("flags", {13'd0, flags}, {13'd0, steps[exp_idx].exp_flags});
                exp_idx++;
                result_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout after %0d cycles, results stopped arriving", cycle_count);
            stop_on_failure();
        end
    end

endmodule

/* verilog.f */
source/cpu_pkg.sv
source/ex_bus_if.sv
source/reg_file.sv
source/decode_stage.sv
source/alu.sv
source/execute_stage.sv
source/exec_core.sv
dv/exec_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the exec_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module exec_core_tb -Mdir obj_dir -o sim

# The log decides the outcome
./obj_dir/sim 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
grep -q "Regression passed" sim.log
